/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dcache_geom_pkg.sv
      - dcache_ctrl_pkg.sv
      - dcache_ctrl.sv
      - dcache_way_store.sv
      - dcache_line_path.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_slow_mem.sv
      - tb_dcache_top.sv

/* dcache_consts.svh */
// data cache geometry

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ------------------------------------------------------------
// word and address widths
// ------------------------------------------------------------
`define DC_WORD_W    32  // processor data word
`define DC_ADDR_W    30  // processor word address

// address split: tag | index | offset
`define DC_OFFSET_W  2   // word within line
`define DC_INDEX_W   2   // set select
`define DC_TAG_W     26

// ------------------------------------------------------------
// line and set count
// ------------------------------------------------------------
`define DC_LINE_W    128 // four words per line
`define DC_SETS      4

`endif

/* dcache_ctrl.sv */
// data cache controller

`default_nettype none

module dcache_ctrl import dcache_ctrl_pkg::*; (
	input  logic clk,
	input  logic proc_reset,
	input  logic proc_read,
	input  logic proc_write,
	input  logic hit,
	input  logic victim_dirty,
	input  logic mem_ready,
	output logic proc_stall,
	output logic access,
	output logic store,
	output logic fill,
	output logic clean,
	output logic mem_read,
	output logic mem_write
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic        req;
	logic        miss;

	assign req  = proc_read | proc_write;
	assign miss = req & ~hit;

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				state_nxt = COMPARE_TAG;
			end
			COMPARE_TAG: begin
				if (miss) begin
					// victim must go out before the fill
					state_nxt = victim_dirty ? WRITE_BACK : ALLOCATE;
				end
			end
			WRITE_BACK: begin
				if (mem_ready) begin
					state_nxt = ALLOCATE;
				end
			end
			ALLOCATE: begin
				if (mem_ready) begin
					state_nxt = COMPARE_TAG; // retry, hits next cycle
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ------------------------------------------------------------
	// outputs and strobes
	// ------------------------------------------------------------
	always_comb begin
		proc_stall = 1'b1;
		access     = 1'b0;
		store      = 1'b0;
		fill       = 1'b0;
		clean      = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		case (state)
			COMPARE_TAG: begin
				proc_stall = miss;
				access     = req & hit;
				store      = proc_write & hit;
			end
			WRITE_BACK: begin
				mem_write = 1'b1;      // held until ready
				clean     = mem_ready;
			end
			ALLOCATE: begin
				mem_read = 1'b1;
				fill     = mem_ready;
			end
			default: begin
				proc_stall = 1'b1; // idle
			end
		endcase
	end

	// a memory request holds steady until the memory answers
	a_req_hold: assert property (@(posedge clk) disable iff (proc_reset)
		((mem_read || mem_write) && !mem_ready) |=> ($stable(mem_read) && $stable(mem_write)));
	// the retried access hits once its line is in
	a_fill_hit: assert property (@(posedge clk) disable iff (proc_reset)
		fill |=> hit);

endmodule

`default_nettype wire

/* dcache_ctrl_pkg.sv */
// data cache controller types

`default_nettype none

package dcache_ctrl_pkg;

	// controller states
	typedef enum logic [1:0] {
		COMPARE_TAG = 2'b00, // hit service, miss detect
		WRITE_BACK  = 2'b01, // dirty victim out to memory
		ALLOCATE    = 2'b10, // line fill from memory
		IDLE        = 2'b11  // one cycle after reset
	} ctrl_state_e;

endpackage

`default_nettype wire

/* dcache_geom_pkg.sv */
// data cache geometry types

`default_nettype none

`include "dcache_consts.svh"

package dcache_geom_pkg;

	// processor side
	typedef logic [`DC_ADDR_W-1:0] addr_t;   // word address
	typedef logic [`DC_WORD_W-1:0] word_t;

	// fields of a processor address
	typedef logic [`DC_TAG_W-1:0]   tag_t;
	typedef logic [`DC_INDEX_W-1:0] index_t;

	// memory side, tag and index together
	typedef logic [`DC_TAG_W+`DC_INDEX_W-1:0] block_addr_t;
	typedef logic [`DC_LINE_W-1:0]            line_t;

endpackage

`default_nettype wire

/* dcache_line_path.sv */
// data cache word and address path

`default_nettype none

`include "dcache_consts.svh"

module dcache_line_path import dcache_geom_pkg::*; (
	input  addr_t       proc_addr,
	input  word_t       proc_wdata,
	input  line_t       hit_line,
	input  tag_t        victim_tag,
	input  logic        mem_write,
	output word_t       proc_rdata,
	output line_t       store_line,
	output block_addr_t mem_addr
);

	logic [`DC_OFFSET_W-1:0] word_off;
	index_t                  idx;
	block_addr_t             req_block;

	assign word_off  = proc_addr[`DC_OFFSET_W-1:0];
	assign idx       = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign req_block = proc_addr[`DC_ADDR_W-1:`DC_OFFSET_W];

	// ------------------------------------------------------------
	// read word select
	// ------------------------------------------------------------
	assign proc_rdata = hit_line[word_off * `DC_WORD_W +: `DC_WORD_W];

	// ------------------------------------------------------------
	// write merge
	// ------------------------------------------------------------
	always_comb begin
		store_line = hit_line;
		store_line[word_off * `DC_WORD_W +: `DC_WORD_W] = proc_wdata;
	end

	// ------------------------------------------------------------
	// memory address
	// ------------------------------------------------------------
	// write-back targets the victim line in the same set
	always_comb begin
		if (mem_write) begin
			mem_addr = {victim_tag, idx};
		end else begin
			mem_addr = req_block; // fill
		end
	end

endmodule

`default_nettype wire

/* dcache_top.sv */
// data cache top level

`default_nettype none

module dcache_top import dcache_geom_pkg::*; (
	input  logic        clk,
	input  logic        proc_reset,
	// processor side
	input  logic        proc_read,
	input  logic        proc_write,
	input  addr_t       proc_addr,
	input  word_t       proc_wdata,
	output word_t       proc_rdata,
	output logic        proc_stall,
	// memory side
	output logic        mem_read,
	output logic        mem_write,
	output block_addr_t mem_addr,
	output line_t       mem_wdata,
	input  line_t       mem_rdata,
	input  logic        mem_ready
);

	logic  access;
	logic  store;
	logic  fill;
	logic  clean;
	logic  hit;
	logic  victim_dirty;
	line_t hit_line;
	line_t victim_line;
	line_t store_line;
	tag_t  victim_tag;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	dcache_ctrl u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.access       (access),
		.store        (store),
		.fill         (fill),
		.clean        (clean),
		.mem_read     (mem_read),
		.mem_write    (mem_write)
	);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------
	dcache_way_store u_ways (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.access       (access),
		.store        (store),
		.fill         (fill),
		.clean        (clean),
		.proc_addr    (proc_addr),
		.store_line   (store_line),
		.mem_rdata    (mem_rdata),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.hit_line     (hit_line),
		.victim_line  (victim_line),
		.victim_tag   (victim_tag)
	);

	dcache_line_path u_path (
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.hit_line   (hit_line),
		.victim_tag (victim_tag),
		.mem_write  (mem_write),
		.proc_rdata (proc_rdata),
		.store_line (store_line),
		.mem_addr   (mem_addr)
	);

	assign mem_wdata = victim_line; // write-back data

endmodule

`default_nettype wire

/* dcache_way_store.sv */
// two-way tag and data store

`default_nettype none

`include "dcache_consts.svh"

module dcache_way_store import dcache_geom_pkg::*; (
	input  logic  clk,
	input  logic  proc_reset,
	input  logic  access,
	input  logic  store,
	input  logic  fill,
	input  logic  clean,
	input  addr_t proc_addr,
	input  line_t store_line,
	input  line_t mem_rdata,
	output logic  hit,
	output logic  victim_dirty,
	output line_t hit_line,
	output line_t victim_line,
	output tag_t  victim_tag
);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	line_t data_mem [0:1][0:`DC_SETS-1];
	tag_t  tag_mem  [0:1][0:`DC_SETS-1];
	logic  valid    [0:1][0:`DC_SETS-1];
	logic  dirty    [0:1][0:`DC_SETS-1];
	logic  victim_way [0:`DC_SETS-1]; // way replaced on next fill

	index_t     idx;
	tag_t       req_tag;
	logic [1:0] hit_way;
	logic       hit_sel;  // way that hits
	logic       vic_sel;  // way to replace

	assign idx     = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign req_tag = proc_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit_way[w] = valid[w][idx] && (tag_mem[w][idx] == req_tag);
		end
	end

	assign hit     = |hit_way;
	assign hit_sel = hit_way[1];
	assign vic_sel = victim_way[idx];

	assign hit_line     = data_mem[hit_sel][idx];
	assign victim_line  = data_mem[vic_sel][idx];
	assign victim_tag   = tag_mem[vic_sel][idx];
	assign victim_dirty = dirty[vic_sel][idx]; // only set on valid lines

	// ------------------------------------------------------------
	// line data and tags
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (fill) begin
			data_mem[vic_sel][idx] <= mem_rdata;
			tag_mem[vic_sel][idx]  <= req_tag;
		end else if (store) begin
			data_mem[hit_sel][idx] <= store_line; // merged word
		end
	end

	// ------------------------------------------------------------
	// valid, dirty and replacement bits
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				valid[0][s]   <= 1'b0;
				valid[1][s]   <= 1'b0;
				dirty[0][s]   <= 1'b0;
				dirty[1][s]   <= 1'b0;
				victim_way[s] <= 1'b0; // way 0 goes first
			end
		end else begin
			if (fill) begin
				valid[vic_sel][idx] <= 1'b1;
				dirty[vic_sel][idx] <= 1'b0;
				victim_way[idx]     <= ~vic_sel;
			end
			if (clean) begin
				dirty[vic_sel][idx] <= 1'b0; // written back
			end
			if (store) begin
				dirty[hit_sel][idx] <= 1'b1;
			end
			if (access) begin
				victim_way[idx] <= ~hit_sel; // other way is now older
			end
		end
	end

	// a fill always replaces the non-matching way, so a tag lives in one way only
	a_one_hit: assert property (@(posedge clk) disable iff (proc_reset)
		$onehot0(hit_way));

endmodule

`default_nettype wire

/* src.f */
+incdir+.
dcache_geom_pkg.sv
dcache_ctrl_pkg.sv
dcache_ctrl.sv
dcache_way_store.sv
dcache_line_path.sv
dcache_top.sv
tb_slow_mem.sv
tb_dcache_top.sv

/* tb_dcache_top.sv */
// data cache testbench

`default_nettype none

`include "dcache_consts.svh"

module tb_dcache_top import dcache_geom_pkg::*, dcache_ctrl_pkg::*; ();

	localparam int    CLK_PERIOD   = 100;
	localparam int    DRIVE_DELAY  = 10;
	localparam int    RESET_CYCLES = 5;
	localparam int    MEM_LATENCY  = 3;
	localparam word_t FILL_BASE    = 32'h1000_0000;
	localparam int    NUM_OPS      = 50;
	localparam int    NUM_RANDOM   = 40;
	localparam int    WORST_CYCLES = 2 * (MEM_LATENCY + 2) + 4; // write-back plus fill
	localparam int    TIMEOUT      = (RESET_CYCLES + NUM_OPS * WORST_CYCLES + 20) * CLK_PERIOD;
	localparam logic [15:0] LFSR_SEED = 16'd35589;

	// expected stall behavior of one operation
	localparam logic [1:0] EXP_ANY  = 2'd0; // not predicted
	localparam logic [1:0] EXP_HIT  = 2'd1; // completes without stall
	localparam logic [1:0] EXP_MISS = 2'd2; // stalls before completing

	logic        clk;
	logic        proc_reset;
	logic        proc_read;
	logic        proc_write;
	addr_t       proc_addr;
	word_t       proc_wdata;
	word_t       proc_rdata;
	logic        proc_stall;
	logic        mem_read;
	logic        mem_write;
	block_addr_t mem_addr;
	line_t       mem_wdata;
	line_t       mem_rdata;
	logic        mem_ready;
	logic        log_valid;
	block_addr_t log_addr;
	line_t       log_line;

	// ------------------------------------------------------------
	// operation table and reference model
	// ------------------------------------------------------------
	logic       op_write [0:NUM_OPS-1];
	addr_t      op_addr  [0:NUM_OPS-1];
	word_t      op_data  [0:NUM_OPS-1];
	logic [1:0] op_exp   [0:NUM_OPS-1];
	int    n_ops;
	word_t ref_mem  [0:255];
	logic [15:0] lfsr;

	dcache_top DUT (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata),
		.proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	tb_slow_mem #(.LATENCY(MEM_LATENCY), .FILL_BASE(FILL_BASE)) u_mem (
		.clk(clk), .proc_reset(proc_reset),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready),
		.log_valid(log_valid), .log_addr(log_addr), .log_line(log_line)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [`DC_LINE_W-1:0] got,
		input logic [`DC_LINE_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic add_op(input logic wr, input addr_t a, input word_t d,
		input logic [1:0] e);
		op_write[n_ops] = wr;
		op_addr[n_ops]  = a;
		op_data[n_ops]  = d;
		op_exp[n_ops]   = e;
		n_ops++;
	endtask

	task automatic build_table();
		logic [31:0] k;
		logic [31:0] a;
		logic [31:0] d;
		// set 0 with tags 0, 1 and 2
		add_op(1'b0, 30'h001, '0, EXP_MISS);           // cold miss
		add_op(1'b0, 30'h003, '0, EXP_HIT);            // same line hits
		add_op(1'b1, 30'h002, 32'hA5A5_0002, EXP_HIT);
		add_op(1'b0, 30'h002, '0, EXP_HIT);
		add_op(1'b0, 30'h010, '0, EXP_MISS);           // second way
		add_op(1'b1, 30'h011, 32'h5A5A_0011, EXP_HIT);
		add_op(1'b0, 30'h001, '0, EXP_HIT);            // tag 1 now oldest
		add_op(1'b0, 30'h020, '0, EXP_MISS);           // evicts dirty tag 1
		add_op(1'b0, 30'h011, '0, EXP_MISS);           // evicts dirty tag 0, refill
		add_op(1'b0, 30'h002, '0, EXP_MISS);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			take_bits(1, k);
			take_bits(7, a);
			take_bits(32, d);
			add_op(k[0], addr_t'(a[6:0]), d, EXP_ANY);
		end
	endtask

	task automatic run_op(input int i);
		logic stalled;
		stalled    = 1'b0;
		proc_read  = ~op_write[i];
		proc_write = op_write[i];
		proc_addr  = op_addr[i];
		proc_wdata = op_data[i];
		@(negedge clk);
		while (proc_stall) begin
			stalled = 1'b1;
			@(negedge clk);
		end
		if (op_exp[i] != EXP_ANY) begin
			check_value("proc_stall", stalled, op_exp[i] == EXP_MISS);
		end
		if (op_write[i]) begin
			ref_mem[op_addr[i][7:0]] = op_data[i];
		end else begin
			check_value("proc_rdata", proc_rdata, ref_mem[op_addr[i][7:0]]);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// ------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------
	always @(negedge clk) begin
		if (!proc_reset) begin
			check_value("mem_read & mem_write", mem_read & mem_write, 1'b0);
		end
	end

	// write-back must carry the victim's current contents
	always @(negedge clk) begin
		if (log_valid) begin
			check_value("mem_addr", log_addr[27:6], '0);
			for (int w = 0; w < 4; w++) begin
				check_value("mem_wdata", log_line[w*32 +: 32],
					ref_mem[{log_addr[5:0], 2'(w)}]);
			end
		end
	end

	initial begin
		ctrl_state_e st;
		#(TIMEOUT);
		st = DUT.u_ctrl.state;
		$display("timeout: the cache did not finish, controller in state %s", st.name());
		$display("Test failures found");
		$fatal(1);
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		n_ops      = 0;
		lfsr       = LFSR_SEED;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = FILL_BASE + i;
		end
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY proc_reset = 1'b0;
		@(negedge clk); // idle cycle after reset
		check_value("proc_stall", proc_stall, 1'b1);
		check_value("mem_read", mem_read, 1'b0);
		check_value("mem_write", mem_write, 1'b0);
		@(posedge clk);
		#DRIVE_DELAY;
		for (int i = 0; i < n_ops; i++) begin
			run_op(i);
		end
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_slow_mem.sv */
// slow line-wide memory model

`default_nettype none

module tb_slow_mem import dcache_geom_pkg::*; #(
	parameter int    LATENCY   = 3,
	parameter word_t FILL_BASE = 32'h1000_0000
) (
	input  wire logic        clk,
	input  wire logic        proc_reset,
	input  wire logic        mem_read,
	input  wire logic        mem_write,
	input  wire block_addr_t mem_addr,
	input  wire line_t       mem_wdata,
	output      line_t       mem_rdata,
	output      logic        mem_ready,
	// one entry per accepted write
	output      logic        log_valid,
	output      block_addr_t log_addr,
	output      line_t       log_line
);

	line_t    lines   [0:63];
	logic     written [0:63];
	int       wait_cnt;
	logic [5:0] slot;

	assign slot = mem_addr[5:0];

	// unwritten words read back as word address plus a base
	function automatic line_t fill_line(input block_addr_t blk);
		line_t l;
		for (int w = 0; w < 4; w++) begin
			l[w*32 +: 32] = {blk, 2'(w)} + FILL_BASE;
		end
		return l;
	endfunction

	initial begin
		mem_rdata = '0;
		mem_ready = 1'b0;
		log_valid = 1'b0;
		log_addr  = '0;
		log_line  = '0;
		wait_cnt  = 0;
		for (int i = 0; i < 64; i++) begin
			written[i] = 1'b0;
		end
	end

	always @(posedge clk) begin
		log_valid <= 1'b0;
		if (proc_reset) begin
			mem_ready <= 1'b0;
			wait_cnt  <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0; // request drops at this edge
			wait_cnt  <= 0;
		end else if (mem_read || mem_write) begin
			if (wait_cnt == LATENCY - 1) begin
				mem_ready <= 1'b1;
				wait_cnt  <= 0;
				if (mem_write) begin
					lines[slot]   <= mem_wdata;
					written[slot] <= 1'b1;
					log_valid     <= 1'b1;
					log_addr      <= mem_addr;
					log_line      <= mem_wdata;
				end else begin
					mem_rdata <= written[slot] ? lines[slot] : fill_line(mem_addr);
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire
